// ==== hdl/alu_settings.svh ====
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// full register width of the core
`define ALU_XLEN 64

// width used by the *w instruction forms
`define ALU_WLEN 32

`endif

// ==== hdl/alu_pkg.sv ====
package alu_pkg;

    // result function, low three bits of the control word
    typedef enum logic [2:0] {
        func_add   = 3'b000,
        func_sll   = 3'b001,
        func_slt   = 3'b010,
        func_pass2 = 3'b011,
        func_xor   = 3'b100,
        func_srl   = 3'b101,
        func_or    = 3'b110,
        func_and   = 3'b111
    } alu_func_e;

    // M extension ops, same order as funct3
    typedef enum logic [2:0] {
        md_mul    = 3'b000,
        md_mulh   = 3'b001,
        md_mulhsu = 3'b010,
        md_mulhu  = 3'b011,
        md_div    = 3'b100,
        md_divu   = 3'b101,
        md_rem    = 3'b110,
        md_remu   = 3'b111
    } muldiv_op_e;

    // alt is sub for add, unsigned for slt, arithmetic for srl
    typedef struct packed {
        logic      word;
        logic      alt;
        alu_func_e func;
    } alu_ctr_t;

    // adder side flags for branch compare
    typedef struct packed {
        logic less;
        logic zero;
    } alu_flags_t;

endpackage

// ==== hdl/alu_shifter.sv ====
`timescale 1ns/100ps
`include "alu_settings.svh"

module alu_shifter (
    input  logic [`ALU_XLEN-1:0] src_i,
    input  logic [5:0]           shamt_i,
    input  alu_pkg::alu_ctr_t    ctr_i,
    output logic [`ALU_XLEN-1:0] shift_o
);

    localparam int XLEN = `ALU_XLEN;
    localparam int WLEN = `ALU_WLEN;

    logic            left;
    logic            arith;
    logic [5:0]      amt;
    logic [XLEN-1:0] src_rt;
    logic [XLEN-1:0] sh_in;
    logic [XLEN-1:0] sh_out;
    logic [XLEN-1:0] fill_full;
    logic [XLEN-1:0] fill;
    logic            sign_bit;

    function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] v);
        logic [XLEN-1:0] r;
        for (int i = 0; i < XLEN; i++) begin
            r[i] = v[XLEN-1-i];
        end
        return r;
    endfunction

    assign left  = (ctr_i.func == alu_pkg::func_sll);
    assign arith = ctr_i.alt;

    // word shifts only look at five amount bits
    assign amt = ctr_i.word ? {1'b0, shamt_i[4:0]} : shamt_i;

    // right shift of a word must not pull in the upper half
    assign src_rt = ctr_i.word ? {{(XLEN-WLEN){1'b0}}, src_i[WLEN-1:0]} : src_i;

    // one right shifter serves both directions
    assign sh_in  = left ? bit_rev(src_i) : src_rt;
    assign sh_out = sh_in >> amt;

    // vacated top bits, moved down to the low word for word ops
    assign fill_full = ~({XLEN{1'b1}} >> amt);
    assign fill      = ctr_i.word ? (fill_full >> (XLEN - WLEN)) : fill_full;
    assign sign_bit  = ctr_i.word ? src_i[WLEN-1] : src_i[XLEN-1];

    always_comb begin
        if (left) begin
            shift_o = bit_rev(sh_out);
        end else if (arith && sign_bit) begin
            shift_o = sh_out | fill;
        end else begin
            shift_o = sh_out;
        end
    end

endmodule

// ==== hdl/alu_muldiv.sv ====
`timescale 1ns/100ps
`include "alu_settings.svh"

module alu_muldiv (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    start_i,
    input  alu_pkg::muldiv_op_e     op_i,
    input  logic                    word_i,
    input  logic [`ALU_XLEN-1:0]    src1_i,
    input  logic [`ALU_XLEN-1:0]    src2_i,
    output logic [`ALU_XLEN-1:0]    res_o,
    output logic                    done_o
);

    localparam int XLEN = `ALU_XLEN;
    localparam int WLEN = `ALU_WLEN;
    localparam int CW   = $clog2(XLEN);

    typedef enum logic [2:0] {
        st_idle,
        st_mul,
        st_div,
        st_fix,
        st_done
    } state_e;

    state_e                  state_q;
    logic [CW-1:0]           cnt_q;
    alu_pkg::muldiv_op_e     op_q;
    logic [XLEN:0]           a_q;
    logic [XLEN:0]           b_q;
    logic [XLEN-1:0]         quo_q;
    logic [XLEN-1:0]         rem_q;
    logic [XLEN-1:0]         dvs_q;
    logic                    qneg_q;
    logic                    rneg_q;
    logic                    spec_q;
    logic [XLEN-1:0]         res_q;

    logic                    s1_signed;
    logic                    s2_signed;
    logic                    is_div;
    logic [XLEN-1:0]         ext1;
    logic [XLEN-1:0]         ext2;
    logic                    neg1;
    logic                    neg2;
    logic [XLEN-1:0]         int_min;
    logic                    special;
    logic signed [2*XLEN+1:0] prod;
    logic [XLEN:0]           rem_sh;
    logic [XLEN:0]           diff;
    logic                    fix_div;
    logic [XLEN-1:0]         fix_res;

    // operand signedness follows the opcode
    assign s1_signed = op_i inside {alu_pkg::md_mul, alu_pkg::md_mulh, alu_pkg::md_mulhsu,
                                    alu_pkg::md_div, alu_pkg::md_rem};
    assign s2_signed = op_i inside {alu_pkg::md_mul, alu_pkg::md_mulh,
                                    alu_pkg::md_div, alu_pkg::md_rem};
    assign is_div    = op_i inside {alu_pkg::md_div, alu_pkg::md_divu,
                                    alu_pkg::md_rem, alu_pkg::md_remu};

    // word ops take only the low word, extended per signedness
    assign ext1 = word_i ? {{(XLEN-WLEN){s1_signed & src1_i[WLEN-1]}}, src1_i[WLEN-1:0]}
                         : src1_i;
    assign ext2 = word_i ? {{(XLEN-WLEN){s2_signed & src2_i[WLEN-1]}}, src2_i[WLEN-1:0]}
                         : src2_i;
    assign neg1 = s1_signed & ext1[XLEN-1];
    assign neg2 = s2_signed & ext2[XLEN-1];

    // most negative value of the operation width
    assign int_min = word_i ? {{(XLEN-WLEN+1){1'b1}}, {(WLEN-1){1'b0}}}
                            : {1'b1, {(XLEN-1){1'b0}}};

    // divide by zero or signed overflow skips the iterations
    assign special = (ext2 == '0) ||
                     ((op_i inside {alu_pkg::md_div, alu_pkg::md_rem}) &&
                      (ext1 == int_min) && (ext2 == '1));

    assign prod = $signed(a_q) * $signed(b_q);

    // one restoring step
    assign rem_sh = {rem_q, quo_q[XLEN-1]};
    assign diff   = rem_sh - {1'b0, dvs_q};

    assign fix_div = op_q inside {alu_pkg::md_div, alu_pkg::md_divu};

    always_comb begin
        if (spec_q && (b_q[XLEN-1:0] == '0)) begin
            fix_res = fix_div ? '1 : a_q[XLEN-1:0];
        end else if (spec_q) begin
            fix_res = fix_div ? a_q[XLEN-1:0] : '0;
        end else if (fix_div) begin
            fix_res = qneg_q ? -quo_q : quo_q;
        end else begin
            fix_res = rneg_q ? -rem_q : rem_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= st_idle;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    cnt_q <= '0;
                    if (start_i) begin
                        if (!is_div) begin
                            state_q <= st_mul;
                        end else if (special) begin
                            state_q <= st_fix;
                        end else begin
                            state_q <= st_div;
                        end
                    end
                end
                st_mul: state_q <= st_done;
                st_div: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CW'(XLEN-1)) begin
                        state_q <= st_fix;
                    end
                end
                st_fix: state_q <= st_done;
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle && start_i) begin
            op_q   <= op_i;
            a_q    <= {neg1, ext1};
            b_q    <= {neg2, ext2};
            quo_q  <= neg1 ? -ext1 : ext1;
            dvs_q  <= neg2 ? -ext2 : ext2;
            rem_q  <= '0;
            qneg_q <= neg1 ^ neg2;
            rneg_q <= neg1;
            spec_q <= special;
        end else if (state_q == st_mul) begin
            res_q <= (op_q == alu_pkg::md_mul) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
        end else if (state_q == st_div) begin
            if (!diff[XLEN]) begin
                rem_q <= diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= rem_sh[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end else if (state_q == st_fix) begin
            res_q <= fix_res;
        end
    end

    assign res_o  = res_q;
    assign done_o = (state_q == st_done);

endmodule

// ==== hdl/alu_top.sv ====
`timescale 1ns/100ps
`include "alu_settings.svh"

module alu_top (
    input  logic                  clk,
    input  logic                  rst_i,
    input  alu_pkg::alu_ctr_t     ctr_i,
    input  logic                  div_en_i,
    input  alu_pkg::muldiv_op_e   div_sel_i,
    input  logic [`ALU_XLEN-1:0]  src1_i,
    input  logic [`ALU_XLEN-1:0]  src2_i,
    output logic [`ALU_XLEN-1:0]  res_o,
    output alu_pkg::alu_flags_t   flags_o,
    output logic                  not_ok_o
);

    localparam int XLEN = `ALU_XLEN;
    localparam int WLEN = `ALU_WLEN;

    logic            cin;
    logic [XLEN-1:0] src2_cin;
    logic [XLEN-1:0] sum;
    logic            carry;
    logic            overflow;
    logic            less_s;
    logic            less_u;
    logic            slt_less;
    logic            sum_zero;
    logic [XLEN-1:0] shift_res;
    logic [XLEN-1:0] md_res;
    logic            md_done;
    logic [XLEN-1:0] alu_out;

    // sub and both compares run the adder as src1 - src2
    assign cin = (ctr_i.func == alu_pkg::func_slt) ||
                 (ctr_i.func == alu_pkg::func_add && ctr_i.alt);

    assign src2_cin = src2_i ^ {XLEN{cin}};

    assign {carry, sum} = {1'b0, src1_i} + {1'b0, src2_cin} + {{XLEN{1'b0}}, cin};

    assign overflow = (src1_i[XLEN-1] == src2_cin[XLEN-1]) &&
                      (sum[XLEN-1] != src1_i[XLEN-1]);

    assign sum_zero = ~(|sum);
    assign less_s   = sum[XLEN-1] ^ overflow;
    // no carry out of a - b means a borrow
    assign less_u   = carry ^ cin;
    assign slt_less = ctr_i.alt ? less_u : less_s;

    assign flags_o = '{less: slt_less, zero: sum_zero};

    alu_shifter u_shifter (
        .src_i   (src1_i),
        .shamt_i (src2_i[5:0]),
        .ctr_i   (ctr_i),
        .shift_o (shift_res)
    );

    // start is only taken while the unit sits idle
    alu_muldiv u_muldiv (
        .clk     (clk),
        .rst_i   (rst_i),
        .start_i (div_en_i),
        .op_i    (div_sel_i),
        .word_i  (ctr_i.word),
        .src1_i  (src1_i),
        .src2_i  (src2_i),
        .res_o   (md_res),
        .done_o  (md_done)
    );

    always_comb begin
        if (div_en_i) begin
            alu_out = md_res;
        end else begin
            case (ctr_i.func)
                alu_pkg::func_add:   alu_out = sum;
                alu_pkg::func_sll:   alu_out = shift_res;
                alu_pkg::func_srl:   alu_out = shift_res;
                alu_pkg::func_slt:   alu_out = {{(XLEN-1){1'b0}}, slt_less};
                alu_pkg::func_pass2: alu_out = src2_i;
                alu_pkg::func_xor:   alu_out = src1_i ^ src2_i;
                alu_pkg::func_or:    alu_out = src1_i | src2_i;
                default:             alu_out = src1_i & src2_i;
            endcase
        end
    end

    // word forms sign-extend bit 31
    assign res_o = ctr_i.word ? {{(XLEN-WLEN){alu_out[WLEN-1]}}, alu_out[WLEN-1:0]}
                              : alu_out;

    // stall until the unit reports its result
    assign not_ok_o = div_en_i & ~md_done;

endmodule

// ==== tb/alu_tb.sv ====
`timescale 1ns/100ps
`include "alu_settings.svh"

module alu_tb;

    localparam int clk_period = 100;
    // flag column value that is not checked
    localparam logic [1:0] dc = 2'd2;
    localparam logic [`ALU_XLEN-1:0] ones  = '1;
    localparam logic [`ALU_XLEN-1:0] min64 = {1'b1, {(`ALU_XLEN-1){1'b0}}};
    localparam logic [`ALU_XLEN-1:0] pat   = 64'h8123456789abcdef;

    typedef struct packed {
        alu_pkg::alu_ctr_t    ctr;
        logic                 div_en;
        alu_pkg::muldiv_op_e  div_sel;
        logic [`ALU_XLEN-1:0] src1;
        logic [`ALU_XLEN-1:0] src2;
        logic [`ALU_XLEN-1:0] res;
        logic [1:0]           less;
        logic [1:0]           zero;
    } row_t;

    logic                 clk;
    logic                 rst;
    alu_pkg::alu_ctr_t    ctr;
    logic                 div_en;
    alu_pkg::muldiv_op_e  div_sel;
    logic [`ALU_XLEN-1:0] src1;
    logic [`ALU_XLEN-1:0] src2;
    logic [`ALU_XLEN-1:0] res;
    alu_pkg::alu_flags_t  flags;
    logic                 not_ok;

    row_t        rows_q[$];
    int          cycle_cnt = 0;
    int          max_cycles = 0;
    int unsigned seed_val;

    alu_top UUT (
        .clk       (clk),
        .rst_i     (rst),
        .ctr_i     (ctr),
        .div_en_i  (div_en),
        .div_sel_i (div_sel),
        .src1_i    (src1),
        .src2_i    (src2),
        .res_o     (res),
        .flags_o   (flags),
        .not_ok_o  (not_ok)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period/2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > max_cycles) begin
            $display("TEST FAILED");
            $fatal(1, "run went past %0d cycles without finishing", max_cycles);
        end
    end

    task automatic check(input string name, input logic [`ALU_XLEN-1:0] got,
                         input logic [`ALU_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic alu_row(input logic word, input logic alt, input alu_pkg::alu_func_e func,
                           input logic [`ALU_XLEN-1:0] s1, input logic [`ALU_XLEN-1:0] s2,
                           input logic [`ALU_XLEN-1:0] exp_res, input logic [1:0] less,
                           input logic [1:0] zero);
        row_t r;
        r = '{ctr: '{word: word, alt: alt, func: func}, div_en: 1'b0,
              div_sel: alu_pkg::md_mul, src1: s1, src2: s2, res: exp_res,
              less: less, zero: zero};
        rows_q.push_back(r);
    endtask

    task automatic md_row(input logic word, input alu_pkg::muldiv_op_e sel,
                          input logic [`ALU_XLEN-1:0] s1, input logic [`ALU_XLEN-1:0] s2,
                          input logic [`ALU_XLEN-1:0] exp_res);
        row_t r;
        r = '{ctr: '{word: word, alt: 1'b0, func: alu_pkg::func_add}, div_en: 1'b1,
              div_sel: sel, src1: s1, src2: s2, res: exp_res, less: dc, zero: dc};
        rows_q.push_back(r);
    endtask

    // two cycles for multiply, divide by zero and signed overflow
    function automatic int md_latency(input row_t r);
        logic [`ALU_XLEN-1:0] a;
        logic [`ALU_XLEN-1:0] b;
        logic [`ALU_XLEN-1:0] lowest;
        logic                 signed_op;
        a = r.ctr.word ? {{32{r.src1[31]}}, r.src1[31:0]} : r.src1;
        b = r.ctr.word ? {{32{r.src2[31]}}, r.src2[31:0]} : r.src2;
        lowest = r.ctr.word ? 64'hffffffff80000000 : min64;
        signed_op = (r.div_sel == alu_pkg::md_div) || (r.div_sel == alu_pkg::md_rem);
        if ((r.div_sel inside {alu_pkg::md_mul, alu_pkg::md_mulh, alu_pkg::md_mulhsu,
                               alu_pkg::md_mulhu}) || (b == '0) ||
            (signed_op && a == lowest && b == ones)) begin
            return 2;
        end
        return 66;
    endfunction

    task automatic build_table();
        alu_row(0, 0, alu_pkg::func_add, 64'd5, 64'd7, 64'd12, dc, 0);
        alu_row(0, 0, alu_pkg::func_add, ones, 64'd1, 64'd0, dc, 1);
        alu_row(0, 1, alu_pkg::func_add, 64'd5, 64'd7, 64'hfffffffffffffffe, 1, 0);
        alu_row(0, 1, alu_pkg::func_add, 64'h1234, 64'h1234, 64'd0, 0, 1);
        alu_row(1, 0, alu_pkg::func_add, 64'h7fffffff, 64'd1, 64'hffffffff80000000, dc, 0);
        alu_row(1, 0, alu_pkg::func_add, 64'hdeadbeef00000001, 64'd2, 64'd3, dc, 0);
        alu_row(1, 1, alu_pkg::func_add, 64'd5, 64'd7, 64'hfffffffffffffffe, 1, 0);
        alu_row(0, 0, alu_pkg::func_xor, 64'hf0f0, 64'hff00, 64'h0ff0, dc, dc);
        alu_row(0, 0, alu_pkg::func_or, 64'hf0f0, 64'hff00, 64'hfff0, dc, dc);
        alu_row(0, 0, alu_pkg::func_and, 64'hf0f0, 64'hff00, 64'hf000, dc, dc);
        alu_row(0, 0, alu_pkg::func_pass2, 64'd0, pat, pat, dc, dc);
        // set-less-than, signed then unsigned
        alu_row(0, 0, alu_pkg::func_slt, min64, 64'd1, 64'd1, 1, 0);
        alu_row(0, 1, alu_pkg::func_slt, min64, 64'd1, 64'd0, 0, 0);
        alu_row(0, 0, alu_pkg::func_slt, 64'd5, ones, 64'd0, 0, 0);
        alu_row(0, 1, alu_pkg::func_slt, 64'd5, ones, 64'd1, 1, 0);
        alu_row(0, 0, alu_pkg::func_slt, 64'hfffffffffffffffe, ones, 64'd1, 1, 0);
        alu_row(0, 1, alu_pkg::func_slt, 64'd7, 64'd7, 64'd0, 0, 1);
        // shifts of a value negative in both halves
        alu_row(0, 0, alu_pkg::func_sll, pat, 64'd0, pat, dc, dc);
        alu_row(0, 0, alu_pkg::func_sll, pat, 64'd1, 64'h02468acf13579bde, dc, dc);
        alu_row(0, 0, alu_pkg::func_sll, pat, 64'd31, 64'hc4d5e6f780000000, dc, dc);
        alu_row(0, 0, alu_pkg::func_sll, pat, 64'd32, 64'h89abcdef00000000, dc, dc);
        alu_row(0, 0, alu_pkg::func_sll, pat, 64'd63, min64, dc, dc);
        alu_row(0, 0, alu_pkg::func_srl, pat, 64'd0, pat, dc, dc);
        alu_row(0, 0, alu_pkg::func_srl, pat, 64'd1, 64'h4091a2b3c4d5e6f7, dc, dc);
        alu_row(0, 0, alu_pkg::func_srl, pat, 64'd31, 64'h0000000102468acf, dc, dc);
        alu_row(0, 0, alu_pkg::func_srl, pat, 64'd32, 64'h0000000081234567, dc, dc);
        alu_row(0, 0, alu_pkg::func_srl, pat, 64'd63, 64'd1, dc, dc);
        alu_row(0, 1, alu_pkg::func_srl, pat, 64'd1, 64'hc091a2b3c4d5e6f7, dc, dc);
        alu_row(0, 1, alu_pkg::func_srl, pat, 64'd31, 64'hffffffff02468acf, dc, dc);
        alu_row(0, 1, alu_pkg::func_srl, pat, 64'd63, ones, dc, dc);
        alu_row(1, 0, alu_pkg::func_sll, pat, 64'd0, 64'hffffffff89abcdef, dc, dc);
        alu_row(1, 0, alu_pkg::func_sll, pat, 64'd1, 64'h0000000013579bde, dc, dc);
        alu_row(1, 0, alu_pkg::func_sll, pat, 64'd31, 64'hffffffff80000000, dc, dc);
        alu_row(1, 0, alu_pkg::func_srl, pat, 64'd1, 64'h0000000044d5e6f7, dc, dc);
        alu_row(1, 0, alu_pkg::func_srl, pat, 64'd31, 64'd1, dc, dc);
        alu_row(1, 1, alu_pkg::func_srl, pat, 64'd1, 64'hffffffffc4d5e6f7, dc, dc);
        alu_row(1, 1, alu_pkg::func_srl, pat, 64'd63, ones, dc, dc);
        alu_row(1, 1, alu_pkg::func_srl, 64'hffffffff40000000, 64'd4, 64'h04000000, dc, dc);
        // word amounts of 32 and up keep only five bits
        alu_row(1, 0, alu_pkg::func_sll, pat, 64'd32, 64'hffffffff89abcdef, dc, dc);
        alu_row(1, 0, alu_pkg::func_sll, pat, 64'd63, 64'hffffffff80000000, dc, dc);
        alu_row(1, 0, alu_pkg::func_srl, pat, 64'd32, 64'hffffffff89abcdef, dc, dc);
        alu_row(1, 1, alu_pkg::func_srl, pat, 64'd32, 64'hffffffff89abcdef, dc, dc);
        // multiplies
        md_row(0, alu_pkg::md_mul, 64'd6, 64'd7, 64'd42);
        md_row(0, alu_pkg::md_mul, 64'hfffffffffffffffd, 64'd5, 64'hfffffffffffffff1);
        md_row(0, alu_pkg::md_mulh, min64, min64, 64'h4000000000000000);
        md_row(0, alu_pkg::md_mulh, ones, 64'd5, ones);
        md_row(0, alu_pkg::md_mulhsu, ones, ones, ones);
        md_row(0, alu_pkg::md_mulhsu, 64'd2, min64, 64'd1);
        md_row(0, alu_pkg::md_mulhu, ones, ones, 64'hfffffffffffffffe);
        md_row(1, alu_pkg::md_mul, 64'h123456787fffffff, 64'd2, 64'hfffffffffffffffe);
        // divides, then the zero divisor and overflow cases
        md_row(0, alu_pkg::md_div, 64'hfffffffffffffff9, 64'd2, 64'hfffffffffffffffd);
        md_row(0, alu_pkg::md_rem, 64'hfffffffffffffff9, 64'd2, ones);
        md_row(0, alu_pkg::md_div, 64'd7, 64'hfffffffffffffffe, 64'hfffffffffffffffd);
        md_row(0, alu_pkg::md_rem, 64'd7, 64'hfffffffffffffffe, 64'd1);
        md_row(0, alu_pkg::md_divu, 64'd100, 64'd7, 64'd14);
        md_row(0, alu_pkg::md_remu, 64'd100, 64'd7, 64'd2);
        md_row(0, alu_pkg::md_divu, ones, 64'd2, 64'h7fffffffffffffff);
        md_row(0, alu_pkg::md_div, 64'h1234, 64'd0, ones);
        md_row(0, alu_pkg::md_rem, 64'h1234, 64'd0, 64'h1234);
        md_row(0, alu_pkg::md_divu, 64'h1234, 64'd0, ones);
        md_row(0, alu_pkg::md_remu, pat, 64'd0, pat);
        md_row(0, alu_pkg::md_div, min64, ones, min64);
        md_row(0, alu_pkg::md_rem, min64, ones, 64'd0);
        md_row(1, alu_pkg::md_div, 64'h00000000fffffff9, 64'd2, 64'hfffffffffffffffd);
        md_row(1, alu_pkg::md_div, 64'h80000000, 64'hffffffff, 64'hffffffff80000000);
        md_row(1, alu_pkg::md_remu, 64'h80000005, 64'd0, 64'hffffffff80000005);
    endtask

    // called on a falling edge with the unit idle
    task automatic run_row(input row_t r);
        int waited;
        ctr     = r.ctr;
        div_en  = r.div_en;
        div_sel = r.div_sel;
        src2    = r.src2;
        // pass2 ignores src1, so any filler will do
        if (!r.div_en && r.ctr.func == alu_pkg::func_pass2) begin
            src1 = {$urandom(), $urandom()};
        end else begin
            src1 = r.src1;
        end
        if (!r.div_en) begin
            @(negedge clk);
            check("res_o", res, r.res);
            check("not_ok_o", 64'(not_ok), 64'd0);
            if (r.less != dc) begin
                check("flags_o.less", 64'(flags.less), 64'(r.less));
            end
            if (r.zero != dc) begin
                check("flags_o.zero", 64'(flags.zero), 64'(r.zero));
            end
        end else begin
            // still before the edge that takes the start
            #(clk_period/4);
            check("not_ok_o", 64'(not_ok), 64'd1);
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (not_ok);
            check("not_ok_o cycles", 64'(waited), 64'(md_latency(r)));
            check("res_o", res, r.res);
            div_en = 1'b0;
            // unit leaves its done state
            @(negedge clk);
        end
    endtask

    initial begin
        seed_val = $urandom(90405);
        rst      = 1'b1;
        ctr      = '0;
        div_en   = 1'b0;
        div_sel  = alu_pkg::md_mul;
        src1     = '0;
        src2     = '0;
        build_table();
        max_cycles = rows_q.size() * 70 + 20;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check("not_ok_o", 64'(not_ok), 64'd0);
        foreach (rows_q[i]) begin
            run_row(rows_q[i]);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/alu_pkg.sv
hdl/alu_shifter.sv
hdl/alu_muldiv.sv
hdl/alu_top.sv
tb/alu_tb.sv

// ==== Makefile ====
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TOP       ?= alu_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# $fatal in the testbench makes the binary exit nonzero
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
